// ==== conv_checker.sv ====
`timescale 1ns/1ps

module conv_checker (
	input logic clk,
	input logic rst,
	input logic param_cs,
	input logic bias_cs,
	input logic weight_cs,
	input logic input_cs,
	input logic output_we,
	input logic finish
);

	int fail_count = 0;

	// one memory read at a time
	cs_exclusive: assert property (@(posedge clk) disable iff (!rst)
		$onehot0({param_cs, bias_cs, weight_cs, input_cs}))
		else begin
			fail_count++;
			$error("more than one memory select is high");
		end

	we_single: assert property (@(posedge clk) disable iff (!rst)
		output_we |=> !output_we)
		else begin
			fail_count++;
			$error("output_we is high two cycles running");
		end

	finish_apart: assert property (@(posedge clk) disable iff (!rst)
		!(finish && output_we))
		else begin
			fail_count++;
			$error("finish is high together with output_we");
		end

endmodule

bind conv_top conv_checker u_checker (
	.clk, .rst, .param_cs, .bias_cs, .weight_cs, .input_cs, .output_we, .finish
);

// ==== conv_counter.sv ====
`timescale 1ns/1ps

module conv_counter (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	input  logic             phase_clear,
	input  logic             pixel_step,
	input  conv_pkg::dim_t   side,
	input  conv_pkg::ker_t   num_kernel,
	output conv_pkg::phase_t phase,
	output conv_pkg::dim_t   x,
	output conv_pkg::dim_t   y,
	output conv_pkg::ker_t   kernel,
	output conv_pkg::addr_t  out_addr,
	output logic             pixel_last,
	output logic             kernel_last
);

	conv_pkg::dim_t last_pos;

	assign last_pos = side - 1'b1;
	assign pixel_last = (x == last_pos) && (y == last_pos);
	assign kernel_last = (kernel == num_kernel - 1'b1);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			phase <= '0;
		else if (phase_clear)
			phase <= '0;
		else
			phase <= phase + 1'b1;
	end

	// x wraps first, then y, then kernel
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			x <= '0;
			y <= '0;
			kernel <= '0;
			out_addr <= '0;
		end else if (start) begin
			x <= '0;
			y <= '0;
			kernel <= '0;
			out_addr <= '0;
		end else if (pixel_step) begin
			out_addr <= out_addr + 1'b1;
			if (x != last_pos) begin
				x <= x + 1'b1;
			end else begin
				x <= '0;
				if (y != last_pos) begin
					y <= y + 1'b1;
				end else begin
					y <= '0;
					kernel <= kernel_last ? '0 : kernel + 1'b1;
				end
			end
		end
	end

endmodule

// ==== conv_ctrl.sv ====
`timescale 1ns/1ps
`include "conv_macros.svh"

module conv_ctrl (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  logic [31:0]           param_rdata,
	input  conv_pkg::phase_t      phase,
	input  logic                  pixel_last,
	input  logic                  kernel_last,
	output conv_pkg::conv_state_t state,
	output logic                  param_cs,
	output conv_pkg::addr_t       param_addr,
	output logic                  bias_cs,
	output logic                  weight_cs,
	output logic                  bias_load,
	output logic                  coef_load,
	output logic                  phase_clear,
	output logic                  pixel_step,
	output logic                  output_we,
	output logic                  finish,
	output conv_pkg::dim_t        side,
	output conv_pkg::ker_t        num_kernel
);

	conv_pkg::conv_state_t next_state;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			state <= conv_pkg::idle;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			conv_pkg::idle: begin
				if (start)
					next_state = conv_pkg::load_param;
			end
			conv_pkg::load_param: begin
				if (phase == `PARAM_LEN - 1)
					next_state = conv_pkg::load_bias;
			end
			conv_pkg::load_bias: begin
				if (phase == `COEF_LEN - 1)
					next_state = conv_pkg::load_weight;
			end
			conv_pkg::load_weight: begin
				if (phase == `COEF_LEN - 1)
					next_state = conv_pkg::load_window;
			end
			conv_pkg::load_window: begin
				if (phase == `WINDOW_LEN - 1)
					next_state = conv_pkg::calc;
			end
			conv_pkg::calc:
				next_state = conv_pkg::write_out;
			conv_pkg::write_out: begin
				// next pixel, next kernel, or finished
				if (!pixel_last)
					next_state = conv_pkg::load_window;
				else if (!kernel_last)
					next_state = conv_pkg::load_bias;
				else
					next_state = conv_pkg::done;
			end
			default:
				next_state = conv_pkg::idle;
		endcase
	end

	// each state entry starts its phase count at zero
	assign phase_clear = (next_state != state);

	assign param_cs = (state == conv_pkg::load_param) && (phase < `PARAM_LEN - 1);
	assign param_addr = (phase == 0) ? conv_pkg::addr_t'(`PARAM_ADDR_SIDE)
		: conv_pkg::addr_t'(`PARAM_ADDR_KERNELS);

	assign bias_cs = (state == conv_pkg::load_bias) && (phase == 0);
	assign bias_load = (state == conv_pkg::load_bias) && (phase == `COEF_LEN - 1);
	assign weight_cs = (state == conv_pkg::load_weight) && (phase == 0);
	assign coef_load = (state == conv_pkg::load_weight) && (phase == `COEF_LEN - 1);

	assign pixel_step = (state == conv_pkg::write_out);
	assign output_we = (state == conv_pkg::write_out);
	assign finish = (state == conv_pkg::done);

	// read data trails the address by one cycle
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			side <= '0;
			num_kernel <= '0;
		end else if (state == conv_pkg::load_param) begin
			if (phase == `PARAM_ADDR_SIDE + 1)
				side <= param_rdata[`DIM_W-1:0];
			if (phase == `PARAM_ADDR_KERNELS + 1)
				num_kernel <= param_rdata[`KER_W-1:0];
		end
	end

endmodule

// ==== conv_mac.sv ====
`timescale 1ns/1ps
`include "conv_macros.svh"

module conv_mac (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  bias_load,
	input  conv_pkg::bias_t       bias_rdata,
	input  conv_pkg::conv_state_t state,
	input  conv_pkg::pixel_t      taps [`TAPS],
	input  conv_pkg::coef_t       coefs [`TAPS],
	output logic [15:0]           output_wdata
);

	conv_pkg::bias_t bias_q;
	conv_pkg::acc_t acc;
	conv_pkg::acc_t shifted;
	conv_pkg::pixel_t sat;

	always_ff @(posedge clk) begin
		if (bias_load)
			bias_q <= bias_rdata;
	end

	// widen before the multiply
	always_comb begin
		acc = conv_pkg::acc_t'(bias_q);
		for (int t = 0; t < `TAPS; t++)
			acc = acc + conv_pkg::acc_t'(taps[t]) * conv_pkg::acc_t'(coefs[t]);
	end

	// floor shift, then clamp to signed 8 bits
	assign shifted = acc >>> `QUANT_SHIFT;

	always_comb begin
		if (shifted > 127)
			sat = 8'h7f;
		else if (shifted < -128)
			sat = 8'h80;
		else
			sat = shifted[7:0];
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			output_wdata <= '0;
		else if (state == conv_pkg::calc)
			output_wdata <= {{8{sat[7]}}, sat};
	end

endmodule

// ==== conv_macros.svh ====
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// datapath widths
`define ADDR_W 16
`define DIM_W 5
`define KER_W 4
`define PHASE_W 4
`define PIX_W 8
`define BIAS_W 16
`define ACC_W 20

// 3x3 window, 2-bit codebook index per tap
`define TAPS 9
`define CODE_W 2
`define QUANT_SHIFT 5

// phase lengths in cycles
`define PARAM_LEN 3
`define COEF_LEN 2
`define WINDOW_LEN 10

// parameter memory map
`define PARAM_ADDR_SIDE 0
`define PARAM_ADDR_KERNELS 1

`endif

// ==== conv_pkg.sv ====
`include "conv_macros.svh"

package conv_pkg;

	typedef enum logic [2:0] {
		idle,
		load_param,
		load_bias,
		load_weight,
		load_window,
		calc,
		write_out,
		done
	} conv_state_t;

	typedef logic signed [`PIX_W-1:0] pixel_t;
	typedef logic signed [`PIX_W-1:0] coef_t;
	typedef logic signed [`BIAS_W-1:0] bias_t;
	typedef logic signed [`ACC_W-1:0] acc_t;

	typedef logic [`ADDR_W-1:0] addr_t;
	typedef logic [`DIM_W-1:0] dim_t;
	typedef logic [`KER_W-1:0] ker_t;
	typedef logic [`PHASE_W-1:0] phase_t;
	typedef logic [`TAPS*`CODE_W-1:0] code_t;

endpackage

// ==== conv_tb.sv ====
`timescale 1ns/1ps

module conv_tb;

	localparam int NUM_CASES = 5;
	localparam int RAMP = 0;
	localparam int RANDOM = 1;
	localparam int EXTREME = 2;

	logic clk;
	logic rst;
	logic start;
	logic [31:0] w8;
	logic finish;
	logic param_cs;
	conv_pkg::addr_t param_addr;
	logic [31:0] param_rdata = '0;
	logic bias_cs;
	conv_pkg::addr_t bias_addr;
	conv_pkg::bias_t bias_rdata = '0;
	logic weight_cs;
	conv_pkg::addr_t weight_addr;
	conv_pkg::code_t weight_rdata = '0;
	logic input_cs;
	conv_pkg::addr_t input_addr;
	conv_pkg::pixel_t input_rdata = '0;
	logic output_we;
	conv_pkg::addr_t output_addr;
	logic [15:0] output_wdata;

	// side, kernel count, w8 and fill mode per case
	int case_side [NUM_CASES] = '{3, 4, 5, 6, 4};
	int case_kernels [NUM_CASES] = '{1, 2, 3, 2, 2};
	logic [31:0] case_w8 [NUM_CASES] = '{32'h00000020, 32'hfc05fe03, 32'h02fd06f9,
		32'hf804fb07, 32'h8010f07f};
	int case_mode [NUM_CASES] = '{RAMP, RANDOM, RANDOM, RANDOM, EXTREME};

	logic [31:0] param_mem [2];
	logic [15:0] bias_mem [16];
	logic [17:0] weight_mem [16];
	logic [7:0] input_mem [256];
	logic [15:0] expect_mem [4096];
	bit written [4096];
	logic [31:0] rng;
	int writes = 0;
	int finishes = 0;
	int total_outputs = 0;
	int cycles = 0;
	int limit = 0;

	conv_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	// synchronous read memories, data one cycle after the select
	always @(posedge clk) begin
		if (param_cs)
			param_rdata <= param_mem[param_addr[0]];
		if (bias_cs)
			bias_rdata <= bias_mem[bias_addr[3:0]];
		if (weight_cs)
			weight_rdata <= weight_mem[weight_addr[3:0]];
		if (input_cs)
			input_rdata <= input_mem[input_addr[7:0]];
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout: the engine did not finish within %0d cycles", limit);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	end

	task automatic check_write();
		int a;
		a = int'(output_addr);
		assert (a < total_outputs)
			else stop_on_error($sformatf("write to address %0d out of range", a));
		assert (!written[a])
			else stop_on_error($sformatf("address %0d written twice", a));
		assert (output_wdata == expect_mem[a])
			else stop_on_error($sformatf("output %0d is %0d, expected %0d", a,
				$signed(output_wdata), $signed(expect_mem[a])));
		written[a] = 1'b1;
		writes++;
	endtask

	// outputs are stable mid-cycle
	always @(negedge clk) begin
		if (rst) begin
			if (finish)
				finishes++;
			if (output_we)
				check_write();
		end
	end

	task automatic fill_memories(input int side, input int kernels, input int mode);
		param_mem[0] = 32'(side);
		param_mem[1] = 32'(kernels);
		for (int i = 0; i < side * side; i++) begin
			rng = xorshift(rng);
			case (mode)
				RAMP: input_mem[i] = 8'(i);
				RANDOM: input_mem[i] = rng[7:0];
				default: input_mem[i] = 8'd127;
			endcase
		end
		for (int k = 0; k < kernels; k++) begin
			rng = xorshift(rng);
			if (mode == RAMP) begin
				// centre tap code 0, all others code 1
				weight_mem[k] = 18'h15455;
				bias_mem[k] = '0;
			end else if (mode == RANDOM) begin
				weight_mem[k] = rng[17:0];
				bias_mem[k] = 16'(int'(rng[31:21]) - 1024);
			end else begin
				weight_mem[k] = (k % 2 == 0) ? 18'h00000 : 18'h3ffff;
				bias_mem[k] = (k % 2 == 0) ? 16'sd1000 : -16'sd1000;
			end
		end
	endtask

	task automatic build_expected(input int side, input int kernels, input logic [31:0] w);
		int acc;
		int py;
		int px;
		int code;
		logic signed [7:0] coef;
		logic signed [7:0] pix;
		for (int k = 0; k < kernels; k++) begin
			for (int y = 0; y < side; y++) begin
				for (int x = 0; x < side; x++) begin
					acc = int'($signed(bias_mem[k]));
					for (int t = 0; t < 9; t++) begin
						py = y - 1 + t / 3;
						px = x - 1 + t % 3;
						if (py >= 0 && py < side && px >= 0 && px < side) begin
							code = int'(weight_mem[k][2*t +: 2]);
							coef = w[8*code +: 8];
							pix = input_mem[py * side + px];
							acc += int'(pix) * int'(coef);
						end
					end
					acc = acc >>> 5;
					if (acc > 127)
						acc = 127;
					else if (acc < -128)
						acc = -128;
					expect_mem[k * side * side + y * side + x] = 16'(acc);
				end
			end
		end
	endtask

	task automatic run_case(input int c);
		int side;
		int kernels;
		side = case_side[c];
		kernels = case_kernels[c];
		fill_memories(side, kernels, case_mode[c]);
		build_expected(side, kernels, case_w8[c]);
		for (int a = 0; a < 4096; a++)
			written[a] = 1'b0;
		writes = 0;
		finishes = 0;
		total_outputs = kernels * side * side;
		@(posedge clk);
		#2;
		start = 1'b1;
		w8 = case_w8[c];
		@(posedge clk);
		#2;
		start = 1'b0;
		while (finishes == 0)
			@(posedge clk);
		repeat (3) @(posedge clk);
		assert (finishes == 1)
			else stop_on_error($sformatf("finish pulsed %0d times", finishes));
		assert (writes == total_outputs)
			else stop_on_error($sformatf("%0d writes, expected %0d", writes, total_outputs));
	endtask

	initial begin
		rng = 32'd55;
		rst = 1'b0;
		start = 1'b0;
		w8 = '0;
		limit = 16;
		for (int c = 0; c < NUM_CASES; c++)
			limit += 3 + case_kernels[c] * (4 + 12 * case_side[c] * case_side[c]) + 50;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b1;
		// nothing moves before the first start
		repeat (4) begin
			@(negedge clk);
			assert (!finish && !output_we && !param_cs && !bias_cs && !weight_cs && !input_cs)
				else stop_on_error("a select or strobe is high before start");
		end
		for (int c = 0; c < NUM_CASES; c++)
			run_case(c);
		if (dut.u_checker.fail_count == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("the bus checker reported %0d assertion failures",
				dut.u_checker.fail_count);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	end

endmodule

// ==== conv_top.sv ====
`timescale 1ns/1ps
`include "conv_macros.svh"

module conv_top (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  logic [31:0]       w8,
	output logic              finish,
	output logic              param_cs,
	output conv_pkg::addr_t   param_addr,
	input  logic [31:0]       param_rdata,
	output logic              bias_cs,
	output conv_pkg::addr_t   bias_addr,
	input  conv_pkg::bias_t   bias_rdata,
	output logic              weight_cs,
	output conv_pkg::addr_t   weight_addr,
	input  conv_pkg::code_t   weight_rdata,
	output logic              input_cs,
	output conv_pkg::addr_t   input_addr,
	input  conv_pkg::pixel_t  input_rdata,
	output logic              output_we,
	output conv_pkg::addr_t   output_addr,
	output logic [15:0]       output_wdata
);

	conv_pkg::conv_state_t state;
	conv_pkg::phase_t phase;
	conv_pkg::dim_t side;
	conv_pkg::dim_t x;
	conv_pkg::dim_t y;
	conv_pkg::ker_t num_kernel;
	conv_pkg::ker_t kernel;
	conv_pkg::addr_t out_addr;
	conv_pkg::pixel_t taps [`TAPS];
	conv_pkg::coef_t coefs [`TAPS];
	logic bias_load;
	logic coef_load;
	logic phase_clear;
	logic pixel_step;
	logic pixel_last;
	logic kernel_last;

	// bias and weight words are one per kernel
	assign bias_addr = conv_pkg::addr_t'(kernel);
	assign weight_addr = conv_pkg::addr_t'(kernel);
	assign output_addr = out_addr;

	conv_ctrl u_ctrl (
		.clk, .rst, .start, .param_rdata, .phase, .pixel_last, .kernel_last,
		.state, .param_cs, .param_addr, .bias_cs, .weight_cs, .bias_load,
		.coef_load, .phase_clear, .pixel_step, .output_we, .finish,
		.side, .num_kernel
	);

	conv_counter u_counter (
		.clk, .rst, .start, .phase_clear, .pixel_step, .side, .num_kernel,
		.phase, .x, .y, .kernel, .out_addr, .pixel_last, .kernel_last
	);

	conv_window u_window (
		.clk, .rst, .state, .phase, .x, .y, .side, .input_rdata,
		.input_cs, .input_addr, .taps
	);

	conv_weight u_weight (
		.clk, .rst, .start, .w8, .coef_load, .weight_rdata, .coefs
	);

	conv_mac u_mac (
		.clk, .rst, .bias_load, .bias_rdata, .state, .taps, .coefs, .output_wdata
	);

endmodule

// ==== conv_weight.sv ====
`timescale 1ns/1ps
`include "conv_macros.svh"

module conv_weight (
	input  logic            clk,
	input  logic            rst,
	input  logic            start,
	input  logic [31:0]     w8,
	input  logic            coef_load,
	input  conv_pkg::code_t weight_rdata,
	output conv_pkg::coef_t coefs [`TAPS]
);

	logic [31:0] w8_q;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			w8_q <= '0;
		else if (start)
			w8_q <= w8;
	end

	// code c picks byte c of w8, byte 0 is the low byte
	always_ff @(posedge clk) begin
		if (coef_load) begin
			for (int t = 0; t < `TAPS; t++)
				coefs[t] <= w8_q[8*weight_rdata[t*`CODE_W +: `CODE_W] +: 8];
		end
	end

endmodule

// ==== conv_window.sv ====
`timescale 1ns/1ps
`include "conv_macros.svh"

module conv_window (
	input  logic                  clk,
	input  logic                  rst,
	input  conv_pkg::conv_state_t state,
	input  conv_pkg::phase_t      phase,
	input  conv_pkg::dim_t        x,
	input  conv_pkg::dim_t        y,
	input  conv_pkg::dim_t        side,
	input  conv_pkg::pixel_t      input_rdata,
	output logic                  input_cs,
	output conv_pkg::addr_t       input_addr,
	output conv_pkg::pixel_t      taps [`TAPS]
);

	logic [`DIM_W:0] row;
	logic [`DIM_W:0] col;
	logic [1:0] dy;
	logic [1:0] dx;
	logic issue;
	logic in_bounds;
	logic tap_en_q;
	logic tap_valid_q;
	conv_pkg::phase_t tap_idx_q;

	assign issue = (state == conv_pkg::load_window) && (phase < `TAPS);
	assign dy = 2'(phase / 4'd3);
	assign dx = 2'(phase % 4'd3);

	// one extra bit, so a step off the top or left edge wraps high
	assign row = {1'b0, y} + dy - 1'b1;
	assign col = {1'b0, x} + dx - 1'b1;
	assign in_bounds = (row < {1'b0, side}) && (col < {1'b0, side});

	assign input_cs = issue && in_bounds;
	assign input_addr = conv_pkg::addr_t'(row[`DIM_W-1:0]) * conv_pkg::addr_t'(side)
		+ conv_pkg::addr_t'(col[`DIM_W-1:0]);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			tap_en_q <= 1'b0;
			tap_valid_q <= 1'b0;
			tap_idx_q <= '0;
		end else begin
			tap_en_q <= issue;
			tap_valid_q <= in_bounds;
			tap_idx_q <= phase;
		end
	end

	// padding taps take zero
	always_ff @(posedge clk) begin
		if (tap_en_q)
			taps[tap_idx_q] <= tap_valid_q ? input_rdata : '0;
	end

endmodule

// ==== filelist.f ====
+incdir+.
conv_pkg.sv
conv_ctrl.sv
conv_counter.sv
conv_window.sv
conv_weight.sv
conv_mac.sv
conv_top.sv
conv_checker.sv
conv_tb.sv

// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module conv_tb \
	-o conv_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/conv_sim > sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "run failed"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "run ended early"; exit 1; }
exit 0
